// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_core_pkg.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/reg_file.sv
  - hdl/execute_stage.sv
  - hdl/rv_core_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/rv_core_tb.sv

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    input  logic restart_i,
    output logic clk,
    output logic reset_o
);
    int count;

    initial begin
        clk     = 1'b0;
        reset_o = 1'b1;
        count   = RESET_CYCLES;
    end

    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        if (restart_i) begin
            reset_o <= 1'b1;
            count   <= RESET_CYCLES;
        end else if (count > 1) begin
            count <= count - 1;
        end else begin
            reset_o <= 1'b0;
        end
    end

endmodule

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;
    import rv_core_pkg::*;

    localparam addr_t TB_RESET_PC = 32'h0000_1000;
    localparam int    PROG_LEN    = 200;
    localparam int    ERR_LEN     = 12;
    localparam int    ERR_INDEX   = 8;

    typedef struct {
        addr_t     pc;
        instr_t    instr;
        reg_addr_t rd;
        xlen_t     data;
        int        due;
    } retire_t;

    logic       clk, reset_i;
    logic       restart    = 1'b0;
    logic       ar_ready_i = 1'b0;
    logic       r_valid_i  = 1'b0;
    instr_t     r_data_i   = '0;
    logic [1:0] r_resp_i   = 2'b00;
    logic       ar_valid_o, r_ready_o, retire_valid_o, halted_o, fetch_error_o;
    addr_t      ar_addr_o, retire_pc_o;
    instr_t     retire_instr_o;
    reg_addr_t  retire_rd_o;
    xlen_t      retire_data_o;

    instr_t      mem [0:255];
    xlen_t       shadow [0:31];
    retire_t     pending_q [$];
    logic [31:0] lfsr_q = 32'hbd1d;
    bit          pend = 1'b0;
    addr_t       pend_addr, beat_addr, next_addr;
    int          beat_word, err_index = -1;
    int          cyc = 0, errors = 0, retired = 0, total = 0, tests_run = 0;
    bit          timed_out = 1'b0;
    bit          exp_valid = 1'b0;
    addr_t       exp_pc;
    instr_t      exp_instr;
    reg_addr_t   exp_rd;
    xlen_t       exp_data;
    int          exp_due;

    clock_gen clk0 (.restart_i(restart), .clk(clk), .reset_o(reset_i));

    rv_core_top #(.RESET_PC(TB_RESET_PC)) dut0 (
        .clk(clk), .reset_i(reset_i),
        .ar_ready_i(ar_ready_i), .r_valid_i(r_valid_i),
        .r_data_i(r_data_i), .r_resp_i(r_resp_i),
        .ar_valid_o(ar_valid_o), .ar_addr_o(ar_addr_o), .r_ready_o(r_ready_o),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_instr_o(retire_instr_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o), .halted_o(halted_o), .fetch_error_o(fetch_error_o)
    );

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // kinds 0-7 op-imm by funct3, 8 srai, 9-16 op by funct3, 17 sub, 18 sra,
    // 19 lui, 20 auipc, 21 unknown opcode
    function automatic instr_t make_instr(input int kind);
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        logic [5:0]  sh;
        logic [19:0] upper;
        rd    = 5'(take_bits(3)); // x0..x7 only
        rs1   = 5'(take_bits(3));
        rs2   = 5'(take_bits(3));
        imm   = 12'(take_bits(12));
        sh    = 6'(take_bits(6));
        upper = 20'(take_bits(20));
        if (kind == 1 || kind == 5) return {6'b000000, sh, rs1, 3'(kind), rd, 7'h13};
        if (kind < 8) return {imm, rs1, 3'(kind), rd, 7'h13};
        case (kind)
            8:       return {6'b010000, sh, rs1, 3'd5, rd, 7'h13};
            17:      return {7'h20, rs2, rs1, 3'd0, rd, 7'h33};
            18:      return {7'h20, rs2, rs1, 3'd5, rd, 7'h33};
            19:      return {upper, rd, 7'h37};
            20:      return {upper, rd, 7'h17};
            21:      return {upper, rd, 7'h23};
            default: return {7'h00, rs2, rs1, 3'(kind - 9), rd, 7'h33};
        endcase
    endfunction

    // rv64i result of one instruction and the shadow register update
    function automatic retire_t predict(input addr_t pc, input instr_t ins, input int due);
        retire_t    e;
        xlen_t      a, b, imm, upper, res;
        logic [5:0] sh;
        logic       wr;
        a     = shadow[ins[19:15]];
        b     = shadow[ins[24:20]];
        imm   = {{52{ins[31]}}, ins[31:20]};
        upper = {{32{ins[31]}}, ins[31:12], 12'h000};
        wr    = 1'b1;
        res   = '0;
        if (ins[6:0] == 7'h33) begin
            sh = b[5:0];
        end else begin
            sh = ins[25:20];
            b  = imm;
        end
        case (ins[6:0])
            7'h13, 7'h33: begin
                case (ins[14:12])
                    3'd0: res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
                    3'd1: res = a << sh;
                    3'd2: res = {63'd0, $signed(a) < $signed(b)};
                    3'd3: res = {63'd0, a < b};
                    3'd4: res = a ^ b;
                    3'd5: begin
                        if (ins[30]) res = $signed(a) >>> sh;
                        else res = a >> sh;
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            7'h37:   res = upper;
            7'h17:   res = {32'h0, pc} + upper;
            default: wr = 1'b0;
        endcase
        e.pc    = pc;
        e.instr = ins;
        e.due   = due;
        e.rd    = wr ? ins[11:7] : 5'd0;
        e.data  = (e.rd != 0) ? res : '0;
        if (e.rd != 0) shadow[e.rd] = res;
        return e;
    endfunction

    task automatic load_program(input int count, input bit with_ebreak);
        for (int i = 0; i < 256; i++) begin
            mem[i] = {12'(i), 13'd0, 7'h13}; // addi x0, x0, index
        end
        for (int i = 0; i < count; i++) begin
            mem[i] = make_instr(i < 22 ? i : int'(take_bits(8) % 22));
        end
        if (with_ebreak) mem[count] = 32'h0010_0073;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(negedge clk);
        while (!reset_i && n < 20) begin
            @(negedge clk);
            n++;
        end
        while (reset_i && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (reset_i !== 1'b0) begin
            timed_out = 1'b1;
            $display("timeout while waiting for reset to be released");
        end
    endtask

    task automatic wait_drained(input bit want_error, input string what);
        int n;
        n = 0;
        while (!(halted_o && fetch_error_o == want_error && !exp_valid) && n < 5000) begin
            @(negedge clk);
            n++;
        end
        if (!(halted_o && fetch_error_o == want_error && !exp_valid)) begin
            timed_out = 1'b1;
            $display("timeout while waiting for %s", what);
        end
    endtask

    // AXI4-Lite read responder with random ready and valid delays
    always @(posedge clk) begin
        if (reset_i) begin
            ar_ready_i <= 1'b0;
            r_valid_i  <= 1'b0;
            pend = 1'b0;
        end else begin
            ar_ready_i <= (take_bits(1) != 0);
            if (r_valid_i && r_ready_o) r_valid_i <= 1'b0;
            if (ar_valid_o && ar_ready_i) begin
                pend      = 1'b1;
                pend_addr = ar_addr_o;
            end
            if (pend && take_bits(2) != 0) begin // zero delay lets decode bypass from retire
                beat_word = int'((pend_addr - TB_RESET_PC) >> 2);
                beat_addr = pend_addr;
                pend      = 1'b0;
                r_valid_i <= 1'b1;
                r_data_i  <= mem[beat_word[7:0]];
                r_resp_i  <= (beat_word == err_index) ? 2'b10 : 2'b00; // slverr
            end
        end
    end

    // expected retirements in fetch order
    always @(posedge clk) begin
        if (reset_i) begin
            pending_q.delete();
            for (int i = 0; i < 32; i++) begin
                shadow[i] = '0;
            end
            next_addr = TB_RESET_PC;
        end else begin
            if (ar_valid_o && ar_ready_i) next_addr = next_addr + 32'd4;
            if (retire_valid_o && pending_q.size() > 0) begin
                void'(pending_q.pop_front());
                retired++;
            end
            if (r_valid_i && r_ready_o && r_resp_i == 2'b00 && r_data_i != 32'h0010_0073)
                pending_q.push_back(predict(beat_addr, r_data_i, cyc + 3));
        end
        exp_valid = (pending_q.size() > 0);
        if (exp_valid) begin
            exp_pc    = pending_q[0].pc;
            exp_instr = pending_q[0].instr;
            exp_rd    = pending_q[0].rd;
            exp_data  = pending_q[0].data;
            exp_due   = pending_q[0].due;
        end
        cyc++;
    end

    a_reset_quiet: assert property (@(posedge clk) reset_i && $past(reset_i) |->
        !(ar_valid_o || r_ready_o || retire_valid_o || halted_o || fetch_error_o))
        else flag_error("output active during reset");
    a_first_req: assert property (@(posedge clk)
        $fell(reset_i) |=> ar_valid_o && ar_addr_o == TB_RESET_PC)
        else flag_error($sformatf("first request at %h", $sampled(ar_addr_o)));
    a_addr_order: assert property (@(posedge clk) disable iff (reset_i)
        ar_valid_o |-> ar_addr_o == next_addr)
        else flag_error($sformatf("fetch address %h, expected %h",
            $sampled(ar_addr_o), $sampled(next_addr)));
    a_ar_hold: assert property (@(posedge clk) disable iff (reset_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
        else flag_error("request dropped or changed under back-pressure");
    a_one_read: assert property (@(posedge clk) disable iff (reset_i)
        ar_valid_o |-> !pend && !r_valid_i)
        else flag_error("second request while a read is outstanding");
    a_retire_order: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid_o |-> exp_valid && retire_pc_o == exp_pc && retire_instr_o == exp_instr)
        else flag_error($sformatf("retired pc %h instr %h, expected pc %h instr %h",
            $sampled(retire_pc_o), $sampled(retire_instr_o),
            $sampled(exp_pc), $sampled(exp_instr)));
    a_retire_data: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid_o |-> retire_rd_o == exp_rd && retire_data_o == exp_data)
        else flag_error($sformatf("retired x%0d = %h, expected x%0d = %h",
            $sampled(retire_rd_o), $sampled(retire_data_o),
            $sampled(exp_rd), $sampled(exp_data)));
    a_retire_timing: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid_o == (exp_valid && cyc == exp_due))
        else flag_error("retire pulse out of step with its read handshake");
    a_ebreak_halt: assert property (@(posedge clk) disable iff (reset_i)
        r_valid_i && r_ready_o && r_resp_i == 2'b00 && r_data_i == 32'h0010_0073
        |=> halted_o && !fetch_error_o)
        else flag_error("no halt after ebreak");
    a_error_halt: assert property (@(posedge clk) disable iff (reset_i)
        r_valid_i && r_ready_o && r_resp_i != 2'b00 |=> halted_o && fetch_error_o)
        else flag_error("no error halt after a failed read");
    a_halt_quiet: assert property (@(posedge clk) disable iff (reset_i)
        halted_o |-> !ar_valid_o && !r_ready_o)
        else flag_error("fetch active while halted");
    a_drained: assert property (@(posedge clk) disable iff (reset_i)
        halted_o && $past(halted_o, 3) |-> !exp_valid)
        else flag_error("instructions left unretired after halt");

    initial begin
        load_program(PROG_LEN, 1'b1);
        wait_reset_release();
        if (!timed_out) wait_drained(1'b0, "the ebreak halt and the last retirement");
        if (!timed_out) begin
            a_count_prog: assert (retired == PROG_LEN)
                else flag_error($sformatf("%0d retired, expected %0d", retired, PROG_LEN));
            $display("test 1 random program to ebreak: %0d retired, %0d errors",
                retired, errors);
            tests_run++;
            total   += retired;
            retired  = 0;
            load_program(ERR_LEN, 1'b0);
            err_index = ERR_INDEX;
            @(posedge clk);
            restart <= 1'b1;
            @(posedge clk);
            restart <= 1'b0;
            wait_reset_release();
        end
        if (!timed_out) wait_drained(1'b1, "the error halt and the last retirement");
        if (!timed_out) begin
            a_count_err: assert (retired == ERR_INDEX)
                else flag_error($sformatf("%0d retired, expected %0d", retired, ERR_INDEX));
            $display("test 2 error response: %0d retired, %0d errors", retired, errors);
            tests_run++;
            total += retired;
        end
        $display("%0d tests, %0d retired, %0d errors", tests_run, total, errors);
        if (errors == 0 && !timed_out)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   fetch_valid_i,
    input  rv_core_pkg::addr_t     fetch_pc_i,
    input  rv_core_pkg::instr_t    fetch_instr_i,
    input  rv_core_pkg::xlen_t     rs1_data_i,
    input  rv_core_pkg::xlen_t     rs2_data_i,
    input  logic                   ex_valid_i,
    input  rv_core_pkg::reg_addr_t ex_rd_i,
    input  rv_core_pkg::xlen_t     ex_result_i,
    input  logic                   wb_valid_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    input  rv_core_pkg::xlen_t     wb_data_i,
    output rv_core_pkg::reg_addr_t rs1_addr_o,
    output rv_core_pkg::reg_addr_t rs2_addr_o,
    output logic                   issue_valid_o,
    output rv_core_pkg::alu_op_t   issue_op_o,
    output rv_core_pkg::xlen_t     issue_a_o,
    output rv_core_pkg::xlen_t     issue_b_o,
    output rv_core_pkg::reg_addr_t issue_rd_o,
    output rv_core_pkg::addr_t     issue_pc_o,
    output rv_core_pkg::instr_t    issue_instr_o
);
    import rv_core_pkg::*;

    logic       dec_valid_q;
    addr_t      dec_pc_q;
    instr_t     dec_instr_q;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i, imm_u, shamt, imm;
    xlen_t      rs1_fwd, rs2_fwd;
    logic       legal, use_pc, use_zero, use_imm;
    alu_op_t    op;

    // alt picks sub or sra
    function automatic alu_op_t f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // youngest producer wins
    function automatic xlen_t fwd(input reg_addr_t addr, input xlen_t rf_data);
        if (ex_valid_i && ex_rd_i != '0 && ex_rd_i == addr) return ex_result_i;
        if (wb_valid_i && wb_rd_i != '0 && wb_rd_i == addr) return wb_data_i;
        return rf_data;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= fetch_valid_i;
        end
        dec_pc_q    <= fetch_pc_i;
        dec_instr_q <= fetch_instr_i;
    end

    assign funct3     = dec_instr_q[14:12];
    assign funct7     = dec_instr_q[31:25];
    assign rs1_addr_o = dec_instr_q[19:15];
    assign rs2_addr_o = dec_instr_q[24:20];
    assign imm_i      = {{(XLEN-12){dec_instr_q[31]}}, dec_instr_q[31:20]};
    assign imm_u      = {{(XLEN-32){dec_instr_q[31]}}, dec_instr_q[31:12], 12'b0};
    assign shamt      = {{(XLEN-6){1'b0}}, dec_instr_q[25:20]}; // rv64 shifts

    always_comb begin
        op       = ALU_ADD;
        legal    = 1'b0;
        use_pc   = 1'b0;
        use_zero = 1'b0;
        use_imm  = 1'b0;
        imm      = imm_i;
        case (dec_instr_q[6:0])
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                op      = f3_op(funct3, funct3 == F3_SR && dec_instr_q[30]);
                legal   = 1'b1;
                if (funct3 == F3_SLL || funct3 == F3_SR) begin
                    imm   = shamt;
                    legal = (dec_instr_q[31:26] == 6'b000000) ||
                            (funct3 == F3_SR && dec_instr_q[31:26] == 6'b010000);
                end
            end
            OPC_OP: begin
                op    = f3_op(funct3, dec_instr_q[30]);
                legal = (funct7 == F7_BASE) ||
                        (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
            end
            OPC_LUI: begin
                op       = ALU_PASS_B;
                legal    = 1'b1;
                use_zero = 1'b1;
                use_imm  = 1'b1;
                imm      = imm_u;
            end
            OPC_AUIPC: begin
                legal   = 1'b1;
                use_pc  = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            default: ;
        endcase
        if (!legal) begin // no-op adds zero into x0
            op       = ALU_ADD;
            use_pc   = 1'b0;
            use_zero = 1'b1;
            use_imm  = 1'b1;
            imm      = '0;
        end
    end

    always_comb begin
        rs1_fwd = fwd(rs1_addr_o, rs1_data_i);
        rs2_fwd = fwd(rs2_addr_o, rs2_data_i);
    end

    assign issue_valid_o = dec_valid_q;
    assign issue_op_o    = op;
    assign issue_a_o     = use_zero ? '0 :
                           use_pc   ? {{(XLEN-ADDR_W){1'b0}}, dec_pc_q} :
                                      rs1_fwd;
    assign issue_b_o     = use_imm ? imm : rs2_fwd;
    assign issue_rd_o    = legal ? dec_instr_q[11:7] : '0;
    assign issue_pc_o    = dec_pc_q;
    assign issue_instr_o = dec_instr_q;

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   issue_valid_i,
    input  rv_core_pkg::alu_op_t   issue_op_i,
    input  rv_core_pkg::xlen_t     issue_a_i,
    input  rv_core_pkg::xlen_t     issue_b_i,
    input  rv_core_pkg::reg_addr_t issue_rd_i,
    input  rv_core_pkg::addr_t     issue_pc_i,
    input  rv_core_pkg::instr_t    issue_instr_i,
    output logic                   ex_valid_o,
    output rv_core_pkg::reg_addr_t ex_rd_o,
    output rv_core_pkg::xlen_t     ex_result_o,
    output logic                   retire_valid_o,
    output rv_core_pkg::addr_t     retire_pc_o,
    output rv_core_pkg::instr_t    retire_instr_o,
    output rv_core_pkg::reg_addr_t retire_rd_o,
    output rv_core_pkg::xlen_t     retire_data_o
);
    import rv_core_pkg::*;

    logic      ex_valid_q;
    alu_op_t   ex_op_q;
    xlen_t     ex_a_q, ex_b_q;
    reg_addr_t ex_rd_q;
    addr_t     ex_pc_q;
    instr_t    ex_instr_q;
    logic      ret_valid_q;
    xlen_t     result;
    logic [5:0] shamt;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_q  <= 1'b0;
            ret_valid_q <= 1'b0;
        end else begin
            ex_valid_q  <= issue_valid_i;
            ret_valid_q <= ex_valid_q;
        end
        ex_op_q        <= issue_op_i;
        ex_a_q         <= issue_a_i;
        ex_b_q         <= issue_b_i;
        ex_rd_q        <= issue_rd_i;
        ex_pc_q        <= issue_pc_i;
        ex_instr_q     <= issue_instr_i;
        retire_pc_o    <= ex_pc_q;
        retire_instr_o <= ex_instr_q;
        retire_rd_o    <= ex_rd_q;
        retire_data_o  <= (ex_rd_q == '0) ? '0 : result; // x0 reports zero
    end

    assign shamt = ex_b_q[5:0];

    always_comb begin
        case (ex_op_q)
            ALU_ADD:    result = ex_a_q + ex_b_q;
            ALU_SUB:    result = ex_a_q - ex_b_q;
            ALU_SLL:    result = ex_a_q << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(ex_a_q) < $signed(ex_b_q)};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, ex_a_q < ex_b_q};
            ALU_XOR:    result = ex_a_q ^ ex_b_q;
            ALU_SRL:    result = ex_a_q >> shamt;
            ALU_SRA:    result = xlen_t'($signed(ex_a_q) >>> shamt);
            ALU_OR:     result = ex_a_q | ex_b_q;
            ALU_AND:    result = ex_a_q & ex_b_q;
            ALU_PASS_B: result = ex_b_q;
            default:    result = '0;
        endcase
    end

    assign ex_valid_o     = ex_valid_q;
    assign ex_rd_o        = ex_rd_q;
    assign ex_result_o    = result;
    assign retire_valid_o = ret_valid_q;

    // a fetch round trip takes at least two edges
    a_retire_spaced: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid_o |=> !retire_valid_o);

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_core_pkg::addr_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                ar_ready_i,
    input  logic                r_valid_i,
    input  rv_core_pkg::instr_t r_data_i,
    input  logic [1:0]          r_resp_i,
    output logic                ar_valid_o,
    output rv_core_pkg::addr_t  ar_addr_o,
    output logic                r_ready_o,
    output logic                fetch_valid_o,
    output rv_core_pkg::addr_t  fetch_pc_o,
    output rv_core_pkg::instr_t fetch_instr_o,
    output logic                halted_o,
    output logic                fetch_error_o
);
    import rv_core_pkg::*;

    typedef enum logic [1:0] {
        S_REQ,
        S_WAIT,
        S_HALT
    } fetch_state_e;

    fetch_state_e state_q;
    addr_t        pc_q;
    logic         ar_valid_q;
    logic         error_q;
    logic         r_fire;
    logic         resp_ok;
    logic         is_ebreak;

    assign r_fire    = r_ready_o & r_valid_i;
    assign resp_ok   = (r_resp_i == RESP_OKAY);
    assign is_ebreak = (r_data_i == INSTR_EBREAK);

    assign ar_valid_o    = ar_valid_q;
    assign ar_addr_o     = pc_q;
    assign r_ready_o     = (state_q == S_WAIT);
    assign halted_o      = (state_q == S_HALT);
    assign fetch_error_o = error_q;

    // ebreak and errored beats stop here
    assign fetch_valid_o = r_fire & resp_ok & ~is_ebreak;
    assign fetch_pc_o    = pc_q;
    assign fetch_instr_o = r_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= S_REQ;
            pc_q       <= RESET_PC;
            ar_valid_q <= 1'b0;
            error_q    <= 1'b0;
        end else begin
            case (state_q)
                S_REQ: begin
                    if (!ar_valid_q) begin
                        ar_valid_q <= 1'b1; // first request out of reset
                    end else if (ar_ready_i) begin
                        ar_valid_q <= 1'b0;
                        state_q    <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (r_valid_i) begin
                        if (!resp_ok) begin
                            state_q <= S_HALT;
                            error_q <= 1'b1;
                        end else if (is_ebreak) begin
                            state_q <= S_HALT;
                        end else begin
                            pc_q       <= pc_q + 32'd4;
                            ar_valid_q <= 1'b1; // next request right away
                            state_q    <= S_REQ;
                        end
                    end
                end
                default: ; // halted until reset
            endcase
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (reset_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

    a_one_outstanding: assert property (@(posedge clk) disable iff (reset_i)
        !(ar_valid_o && r_ready_o));

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                   clk,
    input  logic                   reset_i,
    input  rv_core_pkg::reg_addr_t rs1_addr_i,
    input  rv_core_pkg::reg_addr_t rs2_addr_i,
    input  logic                   we_i,
    input  rv_core_pkg::reg_addr_t wr_addr_i,
    input  rv_core_pkg::xlen_t     wr_data_i,
    output rv_core_pkg::xlen_t     rs1_data_o,
    output rv_core_pkg::xlen_t     rs2_data_o
);
    import rv_core_pkg::*;

    xlen_t regs [1:31]; // x0 not stored

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // no internal write-through
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int XLEN       = 64;
    localparam int ADDR_W     = 32;
    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam instr_t INSTR_EBREAK = 32'h0010_0073;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // lui
    } alu_op_t;

endpackage

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
    parameter rv_core_pkg::addr_t RESET_PC = '0
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   ar_ready_i,
    input  logic                   r_valid_i,
    input  rv_core_pkg::instr_t    r_data_i,
    input  logic [1:0]             r_resp_i,
    output logic                   ar_valid_o,
    output rv_core_pkg::addr_t     ar_addr_o,
    output logic                   r_ready_o,
    output logic                   retire_valid_o,
    output rv_core_pkg::addr_t     retire_pc_o,
    output rv_core_pkg::instr_t    retire_instr_o,
    output rv_core_pkg::reg_addr_t retire_rd_o,
    output rv_core_pkg::xlen_t     retire_data_o,
    output logic                   halted_o,
    output logic                   fetch_error_o
);
    import rv_core_pkg::*;

    logic      fetch_valid;
    addr_t     fetch_pc;
    instr_t    fetch_instr;
    reg_addr_t rs1_addr, rs2_addr;
    xlen_t     rs1_data, rs2_data;
    logic      issue_valid;
    alu_op_t   issue_op;
    xlen_t     issue_a, issue_b;
    reg_addr_t issue_rd;
    addr_t     issue_pc;
    instr_t    issue_instr;
    logic      ex_valid;
    reg_addr_t ex_rd;
    xlen_t     ex_result;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch0 (
        .clk(clk), .reset_i(reset_i),
        .ar_ready_i(ar_ready_i), .r_valid_i(r_valid_i),
        .r_data_i(r_data_i), .r_resp_i(r_resp_i),
        .ar_valid_o(ar_valid_o), .ar_addr_o(ar_addr_o), .r_ready_o(r_ready_o),
        .fetch_valid_o(fetch_valid), .fetch_pc_o(fetch_pc), .fetch_instr_o(fetch_instr),
        .halted_o(halted_o), .fetch_error_o(fetch_error_o)
    );

    decode_stage decode0 (
        .clk(clk), .reset_i(reset_i),
        .fetch_valid_i(fetch_valid), .fetch_pc_i(fetch_pc), .fetch_instr_i(fetch_instr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_result_i(ex_result),
        .wb_valid_i(retire_valid_o), .wb_rd_i(retire_rd_o), .wb_data_i(retire_data_o),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .issue_valid_o(issue_valid), .issue_op_o(issue_op),
        .issue_a_o(issue_a), .issue_b_o(issue_b), .issue_rd_o(issue_rd),
        .issue_pc_o(issue_pc), .issue_instr_o(issue_instr)
    );

    reg_file rf0 (
        .clk(clk), .reset_i(reset_i),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .we_i(retire_valid_o), .wr_addr_i(retire_rd_o), .wr_data_i(retire_data_o),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    execute_stage exec0 (
        .clk(clk), .reset_i(reset_i),
        .issue_valid_i(issue_valid), .issue_op_i(issue_op),
        .issue_a_i(issue_a), .issue_b_i(issue_b), .issue_rd_i(issue_rd),
        .issue_pc_i(issue_pc), .issue_instr_i(issue_instr),
        .ex_valid_o(ex_valid), .ex_rd_o(ex_rd), .ex_result_o(ex_result),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_instr_o(retire_instr_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o)
    );

endmodule

// ==== rv_core_top.f ====
hdl/rv_core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/rv_core_top.sv
bench/clock_gen.sv
bench/rv_core_tb.sv
